//--- Bender.yml
package:
  name: frontend

sources:
  - logic/frontend_pkg.sv
  - logic/insn_mem.sv
  - logic/fetch_unit.sv
  - logic/insn_decode.sv
  - logic/rob_alloc.sv
  - logic/rename_queue.sv
  - logic/frontend_top.sv
  - target: test
    files:
      - testbench/tb_frontend.sv

//--- build.f
logic/frontend_pkg.sv
logic/insn_mem.sv
logic/fetch_unit.sv
logic/insn_decode.sv
logic/rob_alloc.sv
logic/rename_queue.sv
logic/frontend_top.sv
testbench/tb_frontend.sv

//--- logic/fetch_unit.sv
// fetch stage; IMEM_WORDS a power of two, pc past memory or on a halfword raises an error
module fetch_unit #(
  parameter frontend_pkg::addr_t RESET_ADDR = '0,
  parameter int                  IMEM_WORDS = 256
) (
  input  logic                          clk,
  input  logic                          rst_i,
  output logic [$clog2(IMEM_WORDS)-1:0] imem_addr_o,
  input  logic [31:0]                   imem_data_i,
  input  logic                          flush_i,
  input  frontend_pkg::addr_t           flush_addr_i,
  input  logic                          decode_stall_i,
  output logic                          fetch_de_valid_o,
  output logic                          fetch_de_error_o,
  output frontend_pkg::addr_t           fetch_de_addr_o,
  output logic [31:0]                   fetch_de_insn_o,
  output frontend_pkg::bptag_t          fetch_de_bptag_o,
  output logic                          fetch_de_bptaken_o
);
  import frontend_pkg::*;

  localparam int AW = $clog2(IMEM_WORDS);

  addr_t  pc_q;
  logic   pend_q;
  bptag_t hist_q;
  logic   fault;
  logic   is_branch;
  logic   taken;
  addr_t  br_off;
  addr_t  next_pc;
  logic   advance;

  // pend_q set means imem_data_i holds the word at pc_q
  assign fault = pc_q[1] | (pc_q[31:2] >= IMEM_WORDS);

  // static prediction: backward conditional branches taken
  assign is_branch = ~fault & (imem_data_i[6:0] == 7'b1100011);
  assign taken = is_branch & imem_data_i[31];
  assign br_off = {{20{imem_data_i[31]}}, imem_data_i[7], imem_data_i[30:25],
                   imem_data_i[11:8], 1'b0};
  assign next_pc = taken ? pc_q + br_off : pc_q + 32'd4;

  assign advance = pend_q & ~decode_stall_i;

  // same word is read again while stalled
  assign imem_addr_o = advance ? next_pc[AW+1:2] : pc_q[AW+1:2];

  always_ff @(posedge clk) begin
    if (rst_i) begin
      pc_q <= RESET_ADDR;
      pend_q <= 1'b0;
      hist_q <= '0;
      fetch_de_valid_o <= 1'b0;
    end else if (flush_i) begin
      pc_q <= flush_addr_i;
      pend_q <= 1'b0;
      fetch_de_valid_o <= 1'b0;
    end else begin
      pend_q <= 1'b1;
      if (advance) begin
        pc_q <= next_pc;
        if (is_branch) begin
          hist_q <= {hist_q[14:0], taken};
        end
      end
      if (~decode_stall_i) begin
        fetch_de_valid_o <= pend_q;
      end
    end
  end

  // tag is the history seen before this branch
  always_ff @(posedge clk) begin
    if (advance) begin
      fetch_de_error_o <= fault;
      fetch_de_addr_o <= pc_q;
      fetch_de_insn_o <= imem_data_i;
      fetch_de_bptag_o <= hist_q;
      fetch_de_bptaken_o <= taken;
    end
  end

endmodule

//--- logic/frontend_pkg.sv
// shared front end types and encodings; rsop values must agree with the decode patterns
package frontend_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [6:0]  robid_t;
  typedef logic [4:0]  rsop_t;
  typedef logic [6:0]  retop_t;
  typedef logic [15:0] bptag_t;
  typedef logic [1:0]  ecause_t;

  localparam ecause_t ERR_IALIGN   = 2'd0;
  localparam ecause_t ERR_IFAULT   = 2'd1;
  localparam ecause_t ERR_IILLEGAL = 2'd2;

  // memory ops use {0, store}, alu ops use {0, alt}
  localparam rsop_t      RSOP_JALR   = 5'b10000;
  localparam logic [1:0] RSOP_CPLX   = 2'b11;
  localparam logic [1:0] RSOP_BRANCH = 2'b01;

  // major opcode, insn[6:2]
  typedef enum logic [4:0] {
    OPC_LOAD = 5'd0, OPC_LOADFP, OPC_CUSTOM0, OPC_MISCMEM,
    OPC_OPIMM, OPC_AUIPC, OPC_OPIMM32, OPC_48B0,
    OPC_STORE, OPC_STOREFP, OPC_CUSTOM1, OPC_AMO,
    OPC_OP, OPC_LUI, OPC_OP32, OPC_64B,
    OPC_MADD, OPC_MSUB, OPC_NMSUB, OPC_NMADD,
    OPC_OPFP, OPC_RESERVED0, OPC_CUSTOM2, OPC_48B1,
    OPC_BRANCH, OPC_JALR, OPC_RESERVED1, OPC_JAL,
    OPC_SYSTEM, OPC_RESERVED2, OPC_CUSTOM3, OPC_80B
  } opcode_e;

endpackage

//--- logic/frontend_top.sv
// front end top; uses flags are {rs1, rs2, imm, memory, pc, csr}, imem load only during reset
module frontend_top #(
  parameter frontend_pkg::addr_t RESET_ADDR  = '0,
  parameter int                  IMEM_WORDS  = 256,
  parameter int                  ROB_DEPTH   = 16,
  parameter int                  QUEUE_DEPTH = 8
) (
  input  logic                           clk,
  input  logic                           rst_i,
  input  logic                           imem_we_i,
  input  logic [$clog2(IMEM_WORDS)-1:0]  imem_waddr_i,
  input  logic [31:0]                    imem_wdata_i,
  input  logic                           flush_i,
  input  frontend_pkg::addr_t            flush_addr_i,
  input  logic                           retire_i,
  input  logic                           q_pop_i,
  output logic                           rob_valid_o,
  output frontend_pkg::addr_t            rob_addr_o,
  output logic [5:0]                     rob_rd_o,
  output logic                           rob_error_o,
  output frontend_pkg::ecause_t          rob_ecause_o,
  output frontend_pkg::retop_t           rob_retop_o,
  output frontend_pkg::bptag_t           rob_bptag_o,
  output logic                           rob_bptaken_o,
  output frontend_pkg::addr_t            rob_target_o,
  output frontend_pkg::robid_t           rob_robid_o,
  output logic                           rob_full_o,
  output logic [$clog2(ROB_DEPTH+1)-1:0] rob_count_o,
  output logic                           q_valid_o,
  output frontend_pkg::addr_t            q_addr_o,
  output logic [5:0]                     q_rd_o,
  output frontend_pkg::rsop_t            q_rsop_o,
  output frontend_pkg::robid_t           q_robid_o,
  output logic [5:0]                     q_uses_o,
  output logic [4:0]                     q_rs1_o,
  output logic [4:0]                     q_rs2_o,
  output logic [31:0]                    q_imm_o
);
  import frontend_pkg::*;

  logic [$clog2(IMEM_WORDS)-1:0] imem_raddr;
  logic [31:0] imem_rdata;
  logic        fetch_de_valid;
  logic        fetch_de_error;
  addr_t       fetch_de_addr;
  logic [31:0] fetch_de_insn;
  bptag_t      fetch_de_bptag;
  logic        fetch_de_bptaken;
  logic        decode_stall;
  logic        decode_rename_valid;
  rsop_t       decode_rsop;
  robid_t      decode_robid;
  logic [5:0]  decode_uses;
  logic [4:0]  decode_rs1;
  logic [4:0]  decode_rs2;
  logic [31:0] decode_imm;
  logic        rename_stall;

  insn_mem #(.IMEM_WORDS(IMEM_WORDS)) u_imem (
    .clk, .rd_addr_i(imem_raddr), .rd_data_o(imem_rdata),
    .we_i(imem_we_i), .waddr_i(imem_waddr_i), .wdata_i(imem_wdata_i)
  );

  fetch_unit #(.RESET_ADDR(RESET_ADDR), .IMEM_WORDS(IMEM_WORDS)) u_fetch (
    .clk, .rst_i, .imem_addr_o(imem_raddr), .imem_data_i(imem_rdata),
    .flush_i, .flush_addr_i, .decode_stall_i(decode_stall),
    .fetch_de_valid_o(fetch_de_valid), .fetch_de_error_o(fetch_de_error),
    .fetch_de_addr_o(fetch_de_addr), .fetch_de_insn_o(fetch_de_insn),
    .fetch_de_bptag_o(fetch_de_bptag), .fetch_de_bptaken_o(fetch_de_bptaken)
  );

  insn_decode u_decode (
    .clk, .rst_i,
    .fetch_de_valid_i(fetch_de_valid), .fetch_de_error_i(fetch_de_error),
    .fetch_de_addr_i(fetch_de_addr), .fetch_de_insn_i(fetch_de_insn),
    .fetch_de_bptag_i(fetch_de_bptag), .fetch_de_bptaken_i(fetch_de_bptaken),
    .decode_stall_o(decode_stall), .decode_addr_o(rob_addr_o), .decode_rd_o(rob_rd_o),
    .decode_rob_valid_o(rob_valid_o), .decode_error_o(rob_error_o),
    .decode_ecause_o(rob_ecause_o), .decode_retop_o(rob_retop_o),
    .decode_bptag_o(rob_bptag_o), .decode_bptaken_o(rob_bptaken_o),
    .decode_target_o(rob_target_o),
    .rob_flush_i(flush_i), .rob_full_i(rob_full_o), .rob_robid_i(rob_robid_o),
    .decode_rename_valid_o(decode_rename_valid), .decode_rsop_o(decode_rsop),
    .decode_robid_o(decode_robid),
    .decode_uses_rs1_o(decode_uses[5]), .decode_uses_rs2_o(decode_uses[4]),
    .decode_uses_imm_o(decode_uses[3]), .decode_uses_memory_o(decode_uses[2]),
    .decode_uses_pc_o(decode_uses[1]), .decode_csr_access_o(decode_uses[0]),
    .decode_rs1_o(decode_rs1), .decode_rs2_o(decode_rs2), .decode_imm_o(decode_imm),
    .rename_stall_i(rename_stall)
  );

  rob_alloc #(.ROB_DEPTH(ROB_DEPTH)) u_rob_alloc (
    .clk, .rst_i, .alloc_i(rob_valid_o), .retire_i, .flush_i,
    .robid_o(rob_robid_o), .full_o(rob_full_o), .count_o(rob_count_o)
  );

  rename_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_rename_queue (
    .clk, .rst_i, .flush_i, .push_i(decode_rename_valid),
    .addr_i(rob_addr_o), .rd_i(rob_rd_o), .rsop_i(decode_rsop), .robid_i(decode_robid),
    .uses_i(decode_uses), .rs1_i(decode_rs1), .rs2_i(decode_rs2), .imm_i(decode_imm),
    .stall_o(rename_stall), .pop_i(q_pop_i), .q_valid_o, .q_addr_o, .q_rd_o,
    .q_rsop_o, .q_robid_o, .q_uses_o, .q_rs1_o, .q_rs2_o, .q_imm_o
  );

endmodule

//--- logic/insn_decode.sv
// RV32I decode stage; no compressed insns, errors reach the ROB only, never rename
module insn_decode (
  input  logic                  clk,
  input  logic                  rst_i,
  input  logic                  fetch_de_valid_i,
  input  logic                  fetch_de_error_i,
  input  frontend_pkg::addr_t   fetch_de_addr_i,
  input  logic [31:0]           fetch_de_insn_i,
  input  frontend_pkg::bptag_t  fetch_de_bptag_i,
  input  logic                  fetch_de_bptaken_i,
  output logic                  decode_stall_o,
  output frontend_pkg::addr_t   decode_addr_o,
  output logic [5:0]            decode_rd_o,
  output logic                  decode_rob_valid_o,
  output logic                  decode_error_o,
  output frontend_pkg::ecause_t decode_ecause_o,
  output frontend_pkg::retop_t  decode_retop_o,
  output frontend_pkg::bptag_t  decode_bptag_o,
  output logic                  decode_bptaken_o,
  output frontend_pkg::addr_t   decode_target_o,
  input  logic                  rob_flush_i,
  input  logic                  rob_full_i,
  input  frontend_pkg::robid_t  rob_robid_i,
  output logic                  decode_rename_valid_o,
  output frontend_pkg::rsop_t   decode_rsop_o,
  output frontend_pkg::robid_t  decode_robid_o,
  output logic                  decode_uses_rs1_o,
  output logic                  decode_uses_rs2_o,
  output logic                  decode_uses_imm_o,
  output logic                  decode_uses_memory_o,
  output logic                  decode_uses_pc_o,
  output logic                  decode_csr_access_o,
  output logic [4:0]            decode_rs1_o,
  output logic [4:0]            decode_rs2_o,
  output logic [31:0]           decode_imm_o,
  input  logic                  rename_stall_i
);
  import frontend_pkg::*;

  logic        valid_q;
  logic        error_q;
  addr_t       addr_q;
  logic [31:0] insn_q;
  bptag_t      bptag_q;
  logic        bptaken_q;

  opcode_e     opc;
  logic [2:0]  funct3;
  logic        fmt_r;
  logic        fmt_i;
  logic        fmt_s;
  logic        fmt_b;
  logic        fmt_u;
  logic        fmt_j;
  logic        fmt_inv;
  logic        insn_load;
  logic        insn_jalr;
  logic        insn_auipc;
  logic        insn_csr;
  logic        uses_rd;

  assign opc = opcode_e'(insn_q[6:2]);
  assign funct3 = insn_q[14:12];
  assign insn_load = (opc == OPC_LOAD);
  assign insn_jalr = (opc == OPC_JALR);
  assign insn_auipc = (opc == OPC_AUIPC);
  assign insn_csr = (opc == OPC_SYSTEM) & (funct3[1:0] != 2'b00);

  always_ff @(posedge clk) begin
    if (rst_i | rob_flush_i) begin
      valid_q <= 1'b0;
    end else if (~decode_stall_o) begin
      valid_q <= fetch_de_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (~decode_stall_o & fetch_de_valid_i) begin
      error_q <= fetch_de_error_i;
      addr_q <= fetch_de_addr_i;
      insn_q <= fetch_de_insn_i;
      bptag_q <= fetch_de_bptag_i;
      bptaken_q <= fetch_de_bptaken_i;
    end
  end

  // format decoder, anything not listed is illegal
  always_comb begin
    {fmt_r, fmt_i, fmt_s, fmt_b, fmt_u, fmt_j, fmt_inv} = '0;
    if (insn_q[1:0] != 2'b11) begin
      fmt_inv = 1'b1;
    end else begin
      case (opc)
        OPC_OP: fmt_r = 1'b1;
        OPC_OPIMM, OPC_LOAD, OPC_JALR, OPC_MISCMEM, OPC_SYSTEM: fmt_i = 1'b1;
        OPC_LUI, OPC_AUIPC: fmt_u = 1'b1;
        OPC_STORE: fmt_s = 1'b1;
        OPC_BRANCH: fmt_b = 1'b1;
        OPC_JAL: fmt_j = 1'b1;
        default: fmt_inv = 1'b1;
      endcase
    end
  end

  always_comb begin
    decode_imm_o = '0;
    case (1'b1)
      fmt_i: decode_imm_o = {{20{insn_q[31]}}, insn_q[31:20]};
      fmt_s: decode_imm_o = {{20{insn_q[31]}}, insn_q[31:25], insn_q[11:7]};
      fmt_b: decode_imm_o = {{20{insn_q[31]}}, insn_q[7], insn_q[30:25], insn_q[11:8], 1'b0};
      fmt_u: decode_imm_o = {insn_q[31:12], 12'b0};
      fmt_j: decode_imm_o = {{12{insn_q[31]}}, insn_q[19:12], insn_q[20], insn_q[30:21], 1'b0};
      default: decode_imm_o = '0;
    endcase
  end

  // rsop priority: memory, complex, jalr, branch, alu
  always_comb begin
    if (decode_uses_memory_o) begin
      decode_rsop_o = {1'b0, fmt_s, funct3};
    end else if (fmt_r & insn_q[25]) begin
      decode_rsop_o = {RSOP_CPLX, funct3};
    end else if (insn_jalr) begin
      decode_rsop_o = RSOP_JALR;
    end else if (fmt_b) begin
      decode_rsop_o = {RSOP_BRANCH, ~|funct3[2:1], funct3[2:1]};
    end else begin
      decode_rsop_o = {1'b0, fmt_r & insn_q[30], funct3};
    end
  end

  assign uses_rd = (fmt_r | fmt_i | fmt_u | fmt_j) & (insn_q[11:7] != 5'd0);

  assign decode_stall_o = rob_full_i | rename_stall_i;
  assign decode_addr_o = addr_q;
  assign decode_rd_o = {~uses_rd, insn_q[11:7]};

  assign decode_rob_valid_o = valid_q & ~rename_stall_i;
  assign decode_error_o = error_q | fmt_inv;
  assign decode_ecause_o = error_q ? (addr_q[1] ? ERR_IALIGN : ERR_IFAULT) : ERR_IILLEGAL;
  assign decode_retop_o = {fmt_b, funct3[0], insn_jalr, fmt_s, funct3};
  assign decode_bptag_o = bptag_q;
  assign decode_bptaken_o = bptaken_q;
  // predicted-taken branch corrects to the fall-through path
  assign decode_target_o = addr_q + ((fmt_b & bptaken_q) ? 32'd4 : decode_imm_o);

  assign decode_rename_valid_o = valid_q & ~decode_error_o & ~rob_full_i;
  assign decode_robid_o = rob_robid_i;
  assign decode_uses_rs1_o = fmt_r | (fmt_i & (~insn_csr | ~funct3[2])) | fmt_s | fmt_b;
  assign decode_uses_rs2_o = fmt_r | fmt_s | fmt_b;
  assign decode_uses_imm_o = ~fmt_r & ~fmt_b;
  assign decode_uses_memory_o = insn_load | fmt_s;
  assign decode_uses_pc_o = fmt_j | insn_jalr | insn_auipc;
  assign decode_csr_access_o = insn_csr;
  assign decode_rs1_o = insn_q[19:15];
  assign decode_rs2_o = insn_q[24:20];

endmodule

//--- logic/insn_mem.sv
// program memory; IMEM_WORDS must be a power of two, read data is one cycle late
module insn_mem #(
  parameter int IMEM_WORDS = 256
) (
  input  logic                          clk,
  input  logic [$clog2(IMEM_WORDS)-1:0] rd_addr_i,
  output logic [31:0]                   rd_data_o,
  input  logic                          we_i,
  input  logic [$clog2(IMEM_WORDS)-1:0] waddr_i,
  input  logic [31:0]                   wdata_i
);

  logic [31:0] mem [IMEM_WORDS];

  always_ff @(posedge clk) begin
    if (we_i) begin
      mem[waddr_i] <= wdata_i;
    end
    rd_data_o <= mem[rd_addr_i];
  end

endmodule

//--- logic/rename_queue.sv
// rename FIFO; QUEUE_DEPTH a power of two, stall at depth minus one so one slot stays spare
module rename_queue #(
  parameter int QUEUE_DEPTH = 8
) (
  input  logic                 clk,
  input  logic                 rst_i,
  input  logic                 flush_i,
  input  logic                 push_i,
  input  frontend_pkg::addr_t  addr_i,
  input  logic [5:0]           rd_i,
  input  frontend_pkg::rsop_t  rsop_i,
  input  frontend_pkg::robid_t robid_i,
  input  logic [5:0]           uses_i,
  input  logic [4:0]           rs1_i,
  input  logic [4:0]           rs2_i,
  input  logic [31:0]          imm_i,
  output logic                 stall_o,
  input  logic                 pop_i,
  output logic                 q_valid_o,
  output frontend_pkg::addr_t  q_addr_o,
  output logic [5:0]           q_rd_o,
  output frontend_pkg::rsop_t  q_rsop_o,
  output frontend_pkg::robid_t q_robid_o,
  output logic [5:0]           q_uses_o,
  output logic [4:0]           q_rs1_o,
  output logic [4:0]           q_rs2_o,
  output logic [31:0]          q_imm_o
);
  import frontend_pkg::*;

  localparam int PW = $clog2(QUEUE_DEPTH);
  localparam int W = $bits(addr_t) + 6 + $bits(rsop_t) + $bits(robid_t) + 6 + 10 + 32;

  logic [W-1:0]   mem [QUEUE_DEPTH];
  logic [PW-1:0]  wr_ptr;
  logic [PW-1:0]  rd_ptr;
  logic [PW:0]    count;
  logic           do_push;
  logic           do_pop;

  assign stall_o = (count >= QUEUE_DEPTH - 1);
  // held entries stay valid on decode while stalled, so count them once
  assign do_push = push_i & ~stall_o;
  assign do_pop = pop_i & q_valid_o;
  assign q_valid_o = (count != '0);

  assign {q_addr_o, q_rd_o, q_rsop_o, q_robid_o, q_uses_o, q_rs1_o, q_rs2_o, q_imm_o} =
    mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= {addr_i, rd_i, rsop_i, robid_i, uses_i, rs1_i, rs2_i, imm_i};
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i | flush_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count <= count + do_push - do_pop;
    end
  end

endmodule

//--- logic/rob_alloc.sv
// ROB id allocator; ROB_DEPTH at most 128, ids keep counting across a flush
module rob_alloc #(
  parameter int ROB_DEPTH = 16
) (
  input  logic                           clk,
  input  logic                           rst_i,
  input  logic                           alloc_i,
  input  logic                           retire_i,
  input  logic                           flush_i,
  output frontend_pkg::robid_t           robid_o,
  output logic                           full_o,
  output logic [$clog2(ROB_DEPTH+1)-1:0] count_o
);

  logic do_alloc;
  logic do_retire;

  assign full_o = (count_o == ROB_DEPTH);
  assign do_alloc = alloc_i & ~full_o;
  // retire on an empty allocator is ignored
  assign do_retire = retire_i & (count_o != '0);

  always_ff @(posedge clk) begin
    if (rst_i) begin
      robid_o <= '0;
      count_o <= '0;
    end else if (flush_i) begin
      count_o <= '0;
    end else begin
      if (do_alloc) begin
        robid_o <= (robid_o == ROB_DEPTH - 1) ? '0 : robid_o + 1'b1;
      end
      case ({do_alloc, do_retire})
        2'b10: count_o <= count_o + 1'b1;
        2'b01: count_o <= count_o - 1'b1;
        default: count_o <= count_o;
      endcase
    end
  end

endmodule

//--- testbench/frontend_patterns.txt
// addr word err cause rsop imm rs1 rs2 rd flags target, all hex, lines in decode order
// flags: bit7 flush to this addr first, bit6 predicted taken, bits5:0 {rs1,rs2,imm,mem,pc,csr}
00000000 00500093 0 0 00 00000005 00 05 01 28 00000005
00000004 12345137 0 0 05 12345000 08 03 02 08 12345004
00000008 002081b3 0 0 00 00000000 01 02 03 30 00000008
0000000c 40118233 0 0 08 00000000 03 01 04 30 0000000c
00000010 022082b3 0 0 18 00000000 01 02 05 30 00000010
00000014 0080a303 0 0 02 00000008 01 08 06 2c 0000001c
00000018 fe612e23 0 0 0a fffffffc 02 06 3c 3c 00000014
0000001c 0000000b 1 2 00 00000000 00 00 00 00 00000000
00000020 deadbee0 1 2 00 00000000 00 00 00 00 00000000
00000024 00209463 0 0 0c 00000008 01 02 28 30 0000002c
00000028 00001397 0 0 01 00001000 00 00 07 0a 00001028
0000002c 010000ef 0 0 00 00000010 00 10 01 0a 0000003c
00000030 00008067 0 0 10 00000000 01 00 20 2a 00000030
00000034 30009473 0 0 01 00000300 01 00 08 29 00000334
00000038 00000013 0 0 00 00000000 00 00 20 28 00000038
0000003c fe20c6e3 0 0 0a ffffffec 01 02 2d 70 00000040
00000028 00001397 0 0 01 00001000 00 00 07 0a 00001028
0000002c 010000ef 0 0 00 00000010 00 10 01 0a 0000003c
00000030 00008067 0 0 10 00000000 01 00 20 2a 00000030
00000034 30009473 0 0 01 00000300 01 00 08 29 00000334
00000038 00000013 0 0 00 00000000 00 00 20 28 00000038
0000003c fe20c6e3 0 0 0a ffffffec 01 02 2d 70 00000040
00000400 00000000 1 1 00 00000000 00 00 00 80 00000000
00000404 00000000 1 1 00 00000000 00 00 00 00 00000000

//--- testbench/tb_frontend.sv
// frontend testbench; default top parameters, pattern file lines are in decode order
module tb_frontend;
  import frontend_pkg::*;

  localparam int IMEM_WORDS = 256;
  localparam int ROB_DEPTH = 16;
  localparam int QUEUE_DEPTH = 8;
  localparam int NLINES = 24;
  localparam int NCOLS = 11;

  logic        clk;
  logic        rst_i;
  logic        imem_we_i;
  logic [7:0]  imem_waddr_i;
  logic [31:0] imem_wdata_i;
  logic        flush_i;
  addr_t       flush_addr_i;
  logic        retire_i;
  logic        q_pop_i;
  logic        rob_valid_o;
  addr_t       rob_addr_o;
  logic [5:0]  rob_rd_o;
  logic        rob_error_o;
  ecause_t     rob_ecause_o;
  retop_t      rob_retop_o;
  bptag_t      rob_bptag_o;
  logic        rob_bptaken_o;
  addr_t       rob_target_o;
  robid_t      rob_robid_o;
  logic        rob_full_o;
  logic [4:0]  rob_count_o;
  logic        q_valid_o;
  addr_t       q_addr_o;
  logic [5:0]  q_rd_o;
  rsop_t       q_rsop_o;
  robid_t      q_robid_o;
  logic [5:0]  q_uses_o;
  logic [4:0]  q_rs1_o;
  logic [4:0]  q_rs2_o;
  logic [31:0] q_imm_o;

  // columns: addr word err cause rsop imm rs1 rs2 rd flags target
  logic [31:0] pat [NLINES*NCOLS];
  int          q_line[$];
  int          q_id[$];
  int          q_count;
  int          rob_idx;
  int          exp_robid;
  bptag_t      exp_hist;
  int          flush_at;
  logic        flush_done;
  logic        seen_full;
  logic        running;

  frontend_top #(
    .RESET_ADDR('0), .IMEM_WORDS(IMEM_WORDS), .ROB_DEPTH(ROB_DEPTH),
    .QUEUE_DEPTH(QUEUE_DEPTH)
  ) dut (.*);

  always #5 clk = ~clk;

  task automatic compare_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    if (expected !== actual) begin
      $display("Error %s expected %h actual %h", name, expected, actual);
      $display("Simulation finished: FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Simulation finished: FAIL");
    $fatal(1, "run aborted");
  endtask

  // retire op: {branch, funct3 bit 0, jalr, store, funct3}
  function automatic retop_t retire_op(input logic [31:0] word);
    logic       branch;
    logic       jalr;
    logic       store;
    logic [2:0] f3;
    branch = (word[6:0] == 7'b1100011);
    jalr = (word[6:0] == 7'b1100111);
    store = (word[6:0] == 7'b0100011);
    f3 = word[14:12];
    return {branch, f3[0], jalr, store, f3};
  endfunction

  // between the last line before a flush and the flush itself
  function automatic logic draining();
    return (rob_idx == flush_at) && !flush_done;
  endfunction

  task automatic record_allocation();
    int    b;
    string t;
    if (rob_idx < NLINES && !draining()) begin
      b = rob_idx * NCOLS;
      t = $sformatf("rob line %0d", rob_idx);
      compare_value({t, " addr"}, pat[b], rob_addr_o);
      compare_value({t, " error"}, pat[b+2], rob_error_o);
      compare_value({t, " robid"}, exp_robid, rob_robid_o);
      // history past a flush also holds the dropped fetches
      if (flush_at < 0 || rob_idx < flush_at) begin
        compare_value({t, " bptag"}, exp_hist, rob_bptag_o);
      end
      if (pat[b+2][0]) begin
        compare_value({t, " cause"}, pat[b+3], rob_ecause_o);
      end else begin
        compare_value({t, " rd"}, pat[b+8], rob_rd_o);
        compare_value({t, " bptaken"}, pat[b+9][6], rob_bptaken_o);
        compare_value({t, " target"}, pat[b+10], rob_target_o);
        compare_value({t, " retop"}, retire_op(pat[b+1]), rob_retop_o);
        if (pat[b+1][6:0] == 7'b1100011) begin
          exp_hist = {exp_hist[14:0], pat[b+9][6]};
        end
        q_line.push_back(rob_idx);
        q_id.push_back(exp_robid);
        q_count++;
      end
      rob_idx++;
    end
    // ids keep counting even for entries that are not compared
    exp_robid = (exp_robid + 1) % ROB_DEPTH;
  endtask

  task automatic check_queue_head();
    int    idx;
    int    id;
    int    b;
    string t;
    if (q_count > 0) begin
      idx = q_line.pop_front();
      id = q_id.pop_front();
      q_count--;
      b = idx * NCOLS;
      t = $sformatf("queue line %0d", idx);
      compare_value({t, " addr"}, pat[b], q_addr_o);
      compare_value({t, " rsop"}, pat[b+4], q_rsop_o);
      compare_value({t, " imm"}, pat[b+5], q_imm_o);
      compare_value({t, " rs1"}, pat[b+6], q_rs1_o);
      compare_value({t, " rs2"}, pat[b+7], q_rs2_o);
      compare_value({t, " rd"}, pat[b+8], q_rd_o);
      compare_value({t, " uses"}, pat[b+9][5:0], q_uses_o);
      compare_value({t, " robid"}, id, q_robid_o);
    end else if (!draining()) begin
      report_failure("queue head holds an operation that was never decoded");
    end
  endtask

  task automatic load_program();
    logic [31:0] a;
    for (int i = 0; i < NLINES; i++) begin
      a = pat[i*NCOLS];
      if (a[31:2] < IMEM_WORDS) begin
        @(negedge clk);
        imem_we_i = 1'b1;
        imem_waddr_i = a[9:2];
        imem_wdata_i = pat[i*NCOLS+1];
      end
    end
    @(negedge clk);
    imem_we_i = 1'b0;
  endtask

  // outputs do not depend on inputs combinationally, so the transfer of the
  // next rising edge is known here
  always @(negedge clk) begin
    if (running) begin
      if (flush_i) begin
        compare_value("flush rob count", 0, rob_count_o);
        compare_value("flush queue valid", 0, q_valid_o);
        flush_i = 1'b0;
        flush_done = 1'b1;
      end
      q_pop_i = ($urandom % 4) != 0;
      retire_i = seen_full && ($urandom % 2 == 0);
      if (draining() && q_count == 0) begin
        flush_i = 1'b1;
        flush_addr_i = pat[flush_at*NCOLS];
      end
      if (rob_full_o) begin
        seen_full = 1'b1;
      end
      if (rob_count_o > ROB_DEPTH) begin
        report_failure("ROB occupancy went past its depth");
      end
      if (!flush_i) begin
        if (q_pop_i && q_valid_o) begin
          check_queue_head();
        end
        if (rob_valid_o && !rob_full_o) begin
          record_allocation();
        end
      end
    end
  end

  initial begin
    clk = 1'b0;
    rst_i = 1'b1;
    imem_we_i = 1'b0;
    imem_waddr_i = '0;
    imem_wdata_i = '0;
    flush_i = 1'b0;
    flush_addr_i = '0;
    retire_i = 1'b0;
    q_pop_i = 1'b0;
    q_count = 0;
    rob_idx = 0;
    exp_robid = 0;
    exp_hist = '0;
    flush_at = -1;
    flush_done = 1'b0;
    seen_full = 1'b0;
    running = 1'b0;
    void'($urandom(78));
    $readmemh("testbench/frontend_patterns.txt", pat);
    for (int i = 0; i < NLINES; i++) begin
      if (pat[i*NCOLS+9][7]) begin
        flush_at = i;
      end
    end
    load_program();
    repeat (10) @(negedge clk);
    rst_i = 1'b0;
    @(posedge clk);
    running = 1'b1;
    wait (rob_idx == NLINES && q_count == 0);
    @(negedge clk);
    compare_value("rob full reached", 1, seen_full);
    $display("Simulation finished: PASS");
    $finish;
  end

  initial begin
    repeat (200 + 40 * NLINES) @(posedge clk);
    report_failure("output stream stalled before all pattern lines were seen");
  end

endmodule
